// File: verilog/satd_pkg.sv
//------------------------------
// satd shared definitions
// residual and coefficient widths, coding unit size codes
// and the number of 4x4 blocks per coding unit
//------------------------------

`default_nettype none

package satd_pkg;

  // residual: 8-bit pixel difference plus sign
  localparam int RESID_W = 9;

  // each 4-point pass grows the word by two bits
  localparam int ROW_W = RESID_W + 2;
  localparam int COL_W = ROW_W + 2;

  // block counter width, holds up to 64 blocks
  localparam int BLK_CNT_W = 7;

  // coding unit size tag
  typedef enum logic [1:0] {
    SIZE_04 = 2'd0,
    SIZE_08 = 2'd1,
    SIZE_16 = 2'd2,
    SIZE_32 = 2'd3
  } size_t;

  // 4x4 blocks in one coding unit
  function automatic logic [BLK_CNT_W-1:0] block_count(input size_t size);
    logic [BLK_CNT_W-1:0] cnt;
    case (size)
      SIZE_04: cnt = 7'd1;
      SIZE_08: cnt = 7'd4;
      SIZE_16: cnt = 7'd16;
      SIZE_32: cnt = 7'd64;
      default: cnt = 7'd1;
    endcase
    return cnt;
  endfunction

endpackage

`default_nettype wire

// File: verilog/satd_row_hadamard.sv
//------------------------------
// satd row stage
// 4-point hadamard over one residual row,
// coefficients and size tag registered on valid
//------------------------------

`default_nettype none

module satd_row_hadamard (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                valid_i,
  input  logic signed [satd_pkg::RESID_W-1:0] resid_i [0:3],
  input  satd_pkg::size_t                     size_i,
  output logic                                row_valid_o,
  output logic signed [satd_pkg::ROW_W-1:0]   coef_o [0:3],
  output satd_pkg::size_t                     size_o
);

  // first butterfly level, one bit of growth
  logic signed [satd_pkg::RESID_W:0] sum01;
  logic signed [satd_pkg::RESID_W:0] dif01;
  logic signed [satd_pkg::RESID_W:0] sum23;
  logic signed [satd_pkg::RESID_W:0] dif23;

  // second level, hadamard row order
  logic signed [satd_pkg::ROW_W-1:0] had [0:3];

  assign sum01 = resid_i[0] + resid_i[1];
  assign dif01 = resid_i[0] - resid_i[1];
  assign sum23 = resid_i[2] + resid_i[3];
  assign dif23 = resid_i[2] - resid_i[3];

  // (+,+,+,+)
  assign had[0] = sum01 + sum23;
  // (+,-,+,-)
  assign had[1] = dif01 + dif23;
  // (+,+,-,-)
  assign had[2] = sum01 - sum23;
  // (+,-,-,+)
  assign had[3] = dif01 - dif23;

  //------------------------------
  // output registers
  //------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      row_valid_o <= 1'b0;
    end else begin
      row_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      for (int k = 0; k < 4; k++) begin
        coef_o[k] <= had[k];
      end
      size_o <= size_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/satd_transpose_buffer.sv
//------------------------------
// satd transpose buffer
// two 4x4 banks, written by rows and read by columns,
// the write side swaps banks so the input never stalls
//------------------------------

`default_nettype none

module satd_transpose_buffer (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              row_valid_i,
  input  logic signed [satd_pkg::ROW_W-1:0] coef_i [0:3],
  input  satd_pkg::size_t                   size_i,
  output logic                              col_valid_o,
  output logic signed [satd_pkg::ROW_W-1:0] col_o [0:3],
  output satd_pkg::size_t                   size_o,
  output logic                              col_last_o
);

  // storage indexed [bank][row][column]
  logic signed [satd_pkg::ROW_W-1:0] bank_q [0:1][0:3][0:3];
  satd_pkg::size_t                   bank_size_q [0:1];

  // write side
  logic       wr_bank_q;
  logic [1:0] wr_row_q;
  // pulse one cycle after a bank fills
  logic       full_q;

  // read side
  logic       rd_active_q;
  logic       rd_bank_q;
  logic [1:0] rd_col_q;

  //------------------------------
  // write control
  //------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_bank_q <= 1'b0;
      wr_row_q  <= 2'd0;
      full_q    <= 1'b0;
    end else begin
      full_q <= row_valid_i && (wr_row_q == 2'd3);
      if (row_valid_i) begin
        wr_row_q <= wr_row_q + 2'd1;
        // fourth row closes the bank
        if (wr_row_q == 2'd3) begin
          wr_bank_q <= ~wr_bank_q;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (row_valid_i) begin
      for (int c = 0; c < 4; c++) begin
        bank_q[wr_bank_q][wr_row_q][c] <= coef_i[c];
      end
      bank_size_q[wr_bank_q] <= size_i;
    end
  end

  //------------------------------
  // read control
  //------------------------------
  // a new full bank may arrive on the same edge that reads column 3,
  // starting the next read right behind it
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_active_q <= 1'b0;
      rd_bank_q   <= 1'b0;
      rd_col_q    <= 2'd0;
    end else if (full_q) begin
      rd_active_q <= 1'b1;
      // write side has already swapped away from the full bank
      rd_bank_q   <= ~wr_bank_q;
      rd_col_q    <= 2'd0;
    end else if (rd_active_q) begin
      rd_col_q <= rd_col_q + 2'd1;
      if (rd_col_q == 2'd3) begin
        rd_active_q <= 1'b0;
      end
    end
  end

  // column outputs
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      col_valid_o <= 1'b0;
      col_last_o  <= 1'b0;
    end else begin
      col_valid_o <= rd_active_q;
      col_last_o  <= rd_active_q && (rd_col_q == 2'd3);
    end
  end

  always_ff @(posedge clk) begin
    if (rd_active_q) begin
      for (int r = 0; r < 4; r++) begin
        col_o[r] <= bank_q[rd_bank_q][r][rd_col_q];
      end
      size_o <= bank_size_q[rd_bank_q];
    end
  end

endmodule

`default_nettype wire

// File: verilog/satd_column_cost.sv
//------------------------------
// satd column stage
// column hadamard, absolute sum per block,
// rounded half of each block added into the coding unit cost
//------------------------------

`default_nettype none

module satd_column_cost #(
  parameter int COST_WIDTH = 16
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              col_valid_i,
  input  logic signed [satd_pkg::ROW_W-1:0] col_i [0:3],
  input  satd_pkg::size_t                   size_i,
  input  logic                              col_last_i,
  output logic                              cost_valid_o,
  output logic [COST_WIDTH-1:0]             cost_o,
  output satd_pkg::size_t                   size_o
);

  // block sum of 16 magnitudes, four bits over one coefficient
  localparam int BLK_W = satd_pkg::COL_W + 4;
  // wide enough for cost plus one block without wrap
  localparam int SUM_W = ((COST_WIDTH > BLK_W) ? COST_WIDTH : BLK_W) + 1;
  localparam logic [COST_WIDTH-1:0] COST_MAX = '1;

  logic signed [satd_pkg::ROW_W:0]   sum01;
  logic signed [satd_pkg::ROW_W:0]   dif01;
  logic signed [satd_pkg::ROW_W:0]   sum23;
  logic signed [satd_pkg::ROW_W:0]   dif23;
  logic signed [satd_pkg::COL_W-1:0] had [0:3];

  // magnitude of -4096 still fits unsigned
  logic [satd_pkg::COL_W-1:0]   abs_val [0:3];
  logic [satd_pkg::COL_W+1:0]   col_sum;

  logic [BLK_W-1:0]             blk_total;
  logic [BLK_W-1:0]             blk_half;
  logic [SUM_W-1:0]             cu_wide;
  logic [COST_WIDTH-1:0]        cu_next;
  logic                         last_blk;

  logic [BLK_W-1:0]               blk_sum_q;
  logic [COST_WIDTH-1:0]          cu_sum_q;
  logic [satd_pkg::BLK_CNT_W-1:0] blk_cnt_q;

  //------------------------------
  // column transform
  //------------------------------
  assign sum01 = col_i[0] + col_i[1];
  assign dif01 = col_i[0] - col_i[1];
  assign sum23 = col_i[2] + col_i[3];
  assign dif23 = col_i[2] - col_i[3];

  assign had[0] = sum01 + sum23;
  assign had[1] = dif01 + dif23;
  assign had[2] = sum01 - sum23;
  assign had[3] = dif01 - dif23;

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      abs_val[k] = had[k][satd_pkg::COL_W-1] ? -had[k] : had[k];
    end
  end

  assign col_sum = abs_val[0] + abs_val[1] + abs_val[2] + abs_val[3];

  //------------------------------
  // block and coding unit sums
  //------------------------------
  assign blk_total = blk_sum_q + col_sum;

  // halve with rounding up
  assign blk_half = (blk_total + 1'b1) >> 1;

  assign cu_wide = cu_sum_q + blk_half;
  assign cu_next = (cu_wide > COST_MAX) ? COST_MAX : cu_wide[COST_WIDTH-1:0];

  // final block of the coding unit
  assign last_blk = (blk_cnt_q == satd_pkg::block_count(size_i) - 1'b1);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      blk_sum_q    <= '0;
      cu_sum_q     <= '0;
      blk_cnt_q    <= '0;
      cost_valid_o <= 1'b0;
    end else begin
      cost_valid_o <= 1'b0;
      if (col_valid_i) begin
        if (col_last_i) begin
          blk_sum_q <= '0;
          if (last_blk) begin
            cu_sum_q     <= '0;
            blk_cnt_q    <= '0;
            cost_valid_o <= 1'b1;
          end else begin
            cu_sum_q  <= cu_next;
            blk_cnt_q <= blk_cnt_q + 1'b1;
          end
        end else begin
          blk_sum_q <= blk_total;
        end
      end
    end
  end

  // result of the coding unit
  always_ff @(posedge clk) begin
    if (col_valid_i && col_last_i && last_blk) begin
      cost_o <= cu_next;
      size_o <= size_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/satd_cost_top.sv
//------------------------------
// satd cost top
// row hadamard, transpose buffer and column cost
// chained as a valid-only stream
//------------------------------

`default_nettype none

module satd_cost_top #(
  parameter int COST_WIDTH = 16
) (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                valid_i,
  input  logic signed [satd_pkg::RESID_W-1:0] resid_i [0:3],
  input  satd_pkg::size_t                     size_i,
  output logic                                cost_valid_o,
  output logic [COST_WIDTH-1:0]               cost_o,
  output satd_pkg::size_t                     size_o
);

  // row stage to buffer
  logic                              row_valid;
  logic signed [satd_pkg::ROW_W-1:0] row_coef [0:3];
  satd_pkg::size_t                   row_size;

  // buffer to column stage
  logic                              col_valid;
  logic signed [satd_pkg::ROW_W-1:0] col_coef [0:3];
  satd_pkg::size_t                   col_size;
  logic                              col_last;

  satd_row_hadamard u_row (
    .clk         (clk),
    .rstn        (rstn),
    .valid_i     (valid_i),
    .resid_i     (resid_i),
    .size_i      (size_i),
    .row_valid_o (row_valid),
    .coef_o      (row_coef),
    .size_o      (row_size)
  );

  satd_transpose_buffer u_buf (
    .clk         (clk),
    .rstn        (rstn),
    .row_valid_i (row_valid),
    .coef_i      (row_coef),
    .size_i      (row_size),
    .col_valid_o (col_valid),
    .col_o       (col_coef),
    .size_o      (col_size),
    .col_last_o  (col_last)
  );

  satd_column_cost #(
    .COST_WIDTH (COST_WIDTH)
  ) u_col (
    .clk          (clk),
    .rstn         (rstn),
    .col_valid_i  (col_valid),
    .col_i        (col_coef),
    .size_i       (col_size),
    .col_last_i   (col_last),
    .cost_valid_o (cost_valid_o),
    .cost_o       (cost_o),
    .size_o       (size_o)
  );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
//------------------------------
// testbench clock and reset
// clock period 8, reset low for 3 cycles
//------------------------------

`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rstn_o
);

  initial clk_o = 1'b0;
  always #(PERIOD / 2) clk_o = ~clk_o;

  initial begin
    rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rstn_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/satd_cost_checker.sv
//------------------------------
// satd cost checker
// rebuilds each 4x4 block from the accepted rows,
// models the coding unit cost and compares every output
//------------------------------

`default_nettype none

module satd_cost_checker #(
  parameter int COST_WIDTH = 16
) (
  input  logic                                clk_i,
  input  logic                                rstn_i,
  input  logic                                valid_i,
  input  logic signed [satd_pkg::RESID_W-1:0] resid_i [0:3],
  input  satd_pkg::size_t                     size_i,
  input  int                                  test_id_i,
  input  logic                                cost_valid_i,
  input  logic [COST_WIDTH-1:0]               cost_i,
  input  satd_pkg::size_t                     cost_size_i,
  output int                                  value_errs_o,
  output int                                  order_errs_o,
  output int                                  pending_o,
  output int                                  sat_cnt_o
);

  // output goes high 7 edges after the last row, first seen one edge later
  localparam int LATENCY  = 7;
  localparam int COST_MAX = (1 << COST_WIDTH) - 1;

  int blk [0:3][0:3];
  int row_idx;
  int blk_idx;
  int cu_acc;
  int cyc;

  // one entry per finished coding unit
  int              exp_cost_q [$];
  satd_pkg::size_t exp_size_q [$];
  int              exp_cyc_q  [$];
  int              exp_test_q [$];

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset_idle";
      2:       return "size04_random";
      3:       return "size_08_16_32_random";
      4:       return "back_to_back";
      5:       return "saturation";
      default: return "mixed_sequence";
    endcase
  endfunction

  // sign of hadamard row k at position n: (+,+,+,+) (+,-,+,-) (+,+,-,-) (+,-,-,+)
  function automatic int hsign(input int k, input int n);
    return ($countones(k & n) % 2) ? -1 : 1;
  endfunction

  // full precision 2-d transform, sum of magnitudes
  function automatic int block_satd();
    int sum;
    int c;
    sum = 0;
    for (int u = 0; u < 4; u++) begin
      for (int v = 0; v < 4; v++) begin
        c = 0;
        for (int i = 0; i < 4; i++) begin
          for (int j = 0; j < 4; j++) begin
            c += hsign(u, i) * hsign(v, j) * blk[i][j];
          end
        end
        sum += (c < 0) ? -c : c;
      end
    end
    return sum;
  endfunction

  task automatic take_row();
    for (int k = 0; k < 4; k++) begin
      blk[row_idx][k] = resid_i[k];
    end
    row_idx++;
    if (row_idx == 4) begin
      row_idx = 0;
      cu_acc  = cu_acc + ((block_satd() + 1) >> 1);
      if (cu_acc > COST_MAX) begin
        cu_acc = COST_MAX;
      end
      blk_idx++;
      if (blk_idx == satd_pkg::block_count(size_i)) begin
        exp_cost_q.push_back(cu_acc);
        exp_size_q.push_back(size_i);
        exp_cyc_q.push_back(cyc + LATENCY + 1);
        exp_test_q.push_back(test_id_i);
        blk_idx = 0;
        cu_acc  = 0;
      end
    end
  endtask

  task automatic check_output();
    int              e_cost;
    int              e_cyc;
    int              e_test;
    satd_pkg::size_t e_size;
    if (exp_cost_q.size() == 0) begin
      $display("unexpected cost output at cycle %0d with no coding unit pending", cyc);
      order_errs_o++;
    end else begin
      e_cost = exp_cost_q.pop_front();
      e_size = exp_size_q.pop_front();
      e_cyc  = exp_cyc_q.pop_front();
      e_test = exp_test_q.pop_front();
      // dut cost pinned at the limit
      if (cost_i === COST_WIDTH'(COST_MAX)) begin
        sat_cnt_o++;
      end
      if (cost_i !== COST_WIDTH'(e_cost)) begin
        $display("error %s: cost expected %0d actual %0d", test_name(e_test), e_cost, cost_i);
        value_errs_o++;
      end
      if (cost_size_i !== e_size) begin
        $display("error %s: size expected %0d actual %0d", test_name(e_test), e_size,
                 cost_size_i);
        value_errs_o++;
      end
      if (cyc != e_cyc) begin
        $display("error %s: output cycle expected %0d actual %0d", test_name(e_test), e_cyc,
                 cyc);
        order_errs_o++;
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (!rstn_i) begin
      row_idx      = 0;
      blk_idx      = 0;
      cu_acc       = 0;
      cyc          = 0;
      value_errs_o = 0;
      order_errs_o = 0;
      sat_cnt_o    = 0;
      exp_cost_q.delete();
      exp_size_q.delete();
      exp_cyc_q.delete();
      exp_test_q.delete();
    end else begin
      cyc++;
      if (cost_valid_i !== 1'b0) begin
        check_output();
      end
      if (valid_i === 1'b1) begin
        take_row();
      end
    end
    pending_o = exp_cost_q.size();
  end

endmodule

`default_nettype wire

// File: tests/satd_cost_tb.sv
//------------------------------
// satd cost testbench
// random coding units from an lcg, checked by a model
//------------------------------

`default_nettype none

module satd_cost_tb;

  localparam int COST_WIDTH  = 16;
  localparam int DRAIN_LIMIT = 200;
  localparam int RESET_LIMIT = 50;

  logic                                clk;
  logic                                rstn;
  logic                                valid;
  logic signed [satd_pkg::RESID_W-1:0] resid [0:3];
  satd_pkg::size_t                     cu_size;
  logic                                cost_valid;
  logic [COST_WIDTH-1:0]               cost;
  satd_pkg::size_t                     cost_size;

  int          test_id;
  logic [31:0] lcg_state;
  int          row_buf [0:3];
  bit          timed_out;
  int          misc_errs;
  int          value_errs;
  int          order_errs;
  int          pending;
  int          sat_cnt;

  tb_clock_gen u_clk (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  satd_cost_top #(
    .COST_WIDTH (COST_WIDTH)
  ) uut (
    .clk          (clk),
    .rstn         (rstn),
    .valid_i      (valid),
    .resid_i      (resid),
    .size_i       (cu_size),
    .cost_valid_o (cost_valid),
    .cost_o       (cost),
    .size_o       (cost_size)
  );

  satd_cost_checker #(
    .COST_WIDTH (COST_WIDTH)
  ) u_check (
    .clk_i        (clk),
    .rstn_i       (rstn),
    .valid_i      (valid),
    .resid_i      (resid),
    .size_i       (cu_size),
    .test_id_i    (test_id),
    .cost_valid_i (cost_valid),
    .cost_i       (cost),
    .cost_size_i  (cost_size),
    .value_errs_o (value_errs),
    .order_errs_o (order_errs),
    .pending_o    (pending),
    .sat_cnt_o    (sat_cnt)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // upper bits have the longer period
  function automatic int rand_below(input int n);
    lcg_state = lcg_next(lcg_state);
    return int'((lcg_state >> 8) % n);
  endfunction

  function automatic int pick_amp();
    case (rand_below(4))
      0:       return 4;
      1:       return 16;
      2:       return 64;
      default: return 256;
    endcase
  endfunction

  task automatic drive_row(input satd_pkg::size_t sz, input int gap);
    @(posedge clk);
    valid   <= 1'b1;
    cu_size <= sz;
    for (int k = 0; k < 4; k++) begin
      resid[k] <= row_buf[k];
    end
    for (int g = 0; g < gap; g++) begin
      @(posedge clk);
      valid <= 1'b0;
    end
  endtask

  task automatic send_cu(input satd_pkg::size_t sz, input int amp, input bit gaps,
                         input bit extreme);
    int gap;
    for (int b = 0; b < satd_pkg::block_count(sz); b++) begin
      for (int r = 0; r < 4; r++) begin
        for (int k = 0; k < 4; k++) begin
          if (extreme) begin
            row_buf[k] = rand_below(2) ? 255 : -256;
          end else begin
            row_buf[k] = rand_below(2 * amp) - amp;
          end
        end
        gap = gaps ? rand_below(4) : 0;
        drive_row(sz, gap);
      end
    end
  endtask

  task automatic wait_reset();
    int cnt;
    cnt = 0;
    while (rstn !== 1'b1 && cnt < RESET_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (rstn !== 1'b1) begin
      $display("timeout: reset was never released");
      timed_out = 1'b1;
      misc_errs++;
    end
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (pending != 0 && cnt < DRAIN_LIMIT);
    if (pending != 0) begin
      $display("timeout: %0d coding unit results never appeared", pending);
      timed_out = 1'b1;
      misc_errs++;
    end
  endtask

  //------------------------------
  // test phases 2 to 6
  //------------------------------
  task automatic run_phase(input int p);
    int              n;
    int              sat_before;
    satd_pkg::size_t sz;
    test_id    <= p;
    sat_before = sat_cnt;
    case (p)
      2:       n = 40;
      3:       n = 12;
      4:       n = 8;
      5:       n = 3;
      default: n = 30;
    endcase
    for (int i = 0; i < n; i++) begin
      case (p)
        2:       sz = satd_pkg::SIZE_04;
        3:       sz = satd_pkg::size_t'(1 + rand_below(3));
        5:       sz = satd_pkg::SIZE_32;
        default: sz = satd_pkg::size_t'(rand_below(4));
      endcase
      // phase 4 keeps valid high across all blocks
      send_cu(sz, pick_amp(), p != 4, p == 5);
    end
    @(posedge clk);
    valid <= 1'b0;
    wait_drain();
    if (p == 5 && !timed_out && sat_cnt - sat_before != n) begin
      $display("saturation test reached the cost limit in only %0d of %0d units",
               sat_cnt - sat_before, n);
      misc_errs++;
    end
  endtask

  initial begin
    valid     = 1'b0;
    cu_size   = satd_pkg::SIZE_04;
    test_id   = 1;
    lcg_state = 32'hcdf;
    timed_out = 1'b0;
    misc_errs = 0;
    for (int k = 0; k < 4; k++) begin
      resid[k] = '0;
    end
    wait_reset();
    // idle after reset, the checker flags any output
    if (!timed_out) begin
      repeat (20) @(posedge clk);
    end
    for (int p = 2; p <= 6; p++) begin
      if (!timed_out) begin
        run_phase(p);
      end
    end
    @(negedge clk);
    $display("value errors %0d, order errors %0d, other errors %0d",
             value_errs, order_errs, misc_errs);
    if (value_errs + order_errs + misc_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
verilog/satd_pkg.sv
verilog/satd_row_hadamard.sv
verilog/satd_transpose_buffer.sv
verilog/satd_column_cost.sv
verilog/satd_cost_top.sv
tests/tb_clock_gen.sv
tests/satd_cost_checker.sv
tests/satd_cost_tb.sv
